/* source/ig_pkg.sv */
`default_nettype none

package ig_pkg;

    // Image geometry. Everything downstream is sized from these.
    localparam int img_w     = 256;
    localparam int img_h     = 256;
    localparam int pix_count = img_w * img_h;

    // Beats needed after the last pixel to push the last two rows out.
    localparam int flush_len = img_w + 1;

    typedef logic [7:0]         pixel_t;     // Unsigned 8-bit pixel.
    typedef logic [15:0]        img_addr_t;  // Raster address, shared by both memories.
    typedef logic signed [9:0]  grad_t;      // Signed pixel difference.

    // Signed view of a gradient word, with Gx in the upper half.
    typedef struct packed {
        grad_t gx;
        grad_t gy;
    } grad_pair_s;

    // A gradient word is stored as a plain 20-bit word but is built and
    // checked as two signed fields.
    typedef union packed {
        logic [19:0] raw;
        grad_pair_s  fields;
    } grad_word_u;

    // One step of the pixel stream.
    typedef struct packed {
        logic   valid;  // A step happens this cycle.
        logic   flush;  // No new pixel in this step.
        pixel_t pixel;  // Zero during flush.
    } pix_beat_s;

endpackage

`default_nettype wire

/* source/image_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module image_reader (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output ig_pkg::img_addr_t img_addr,
    input  ig_pkg::pixel_t    img_di,
    output ig_pkg::pix_beat_s beat
);
    import ig_pkg::*;

    logic       rd_done;   // All addresses have been issued.
    logic       rd_q;      // img_di holds a requested pixel this cycle.
    logic       flushing;
    logic [8:0] flush_cnt;

    // Address sequencer. One read per cycle, raster order, once per run.
    always_ff @(posedge clk) begin
        if (reset) begin
            img_rd   <= 1'b0;
            img_addr <= '0;
            rd_done  <= 1'b0;
        end else if (!img_rd && !rd_done) begin
            img_rd <= 1'b1;  // Address 0 goes out first.
        end else if (img_rd) begin
            if (img_addr == img_addr_t'(pix_count - 1)) begin
                img_rd  <= 1'b0;
                rd_done <= 1'b1;
            end else begin
                img_addr <= img_addr + 1'b1;
            end
        end
    end

    // The memory answers one edge after the request.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= img_rd;
        end
    end

    // Flush beats start right behind the last pixel beat. That beat is the
    // only cycle where rd_q is high while img_rd is already low.
    always_ff @(posedge clk) begin
        if (reset) begin
            flushing  <= 1'b0;
            flush_cnt <= '0;
        end else if (rd_q && !img_rd) begin
            flushing  <= 1'b1;
            flush_cnt <= '0;
        end else if (flushing) begin
            if (flush_cnt == 9'(flush_len - 1)) begin
                flushing <= 1'b0;  // Stream is over for good.
            end else begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        beat.valid = rd_q || flushing;
        beat.flush = flushing;
        beat.pixel = rd_q ? img_di : '0;
    end

endmodule

`default_nettype wire

/* source/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::pix_beat_s beat,
    output ig_pkg::pixel_t    row_tap,
    output ig_pkg::pixel_t    row_tap_prev
);
    import ig_pkg::*;

    // One image row. Slot wr_ptr always holds the pixel from img_w beats ago.
    pixel_t mem [img_w];

    logic [$clog2(img_w)-1:0] wr_ptr;
    logic [$clog2(img_w)-1:0] ahead_ptr;
    pixel_t                   wr_data;

    assign ahead_ptr = wr_ptr + 1'b1;
    assign wr_data   = beat.flush ? '0 : beat.pixel;  // Flush keeps the ring turning.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (beat.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // The slot one ahead is the one the next beat lands on, so reading it now
    // presents the pixel from exactly one row back in step with that beat.
    // It was last written img_w-1 beats ago and is untouched until then.
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            row_tap      <= mem[ahead_ptr];
            row_tap_prev <= row_tap;  // Centre pixel for both difference terms.
        end
    end

endmodule

`default_nettype wire

/* source/gradient_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module gradient_unit (
    input  logic               clk,
    input  logic               reset,
    input  ig_pkg::pix_beat_s  beat,
    input  ig_pkg::pixel_t     row_tap,
    input  ig_pkg::pixel_t     row_tap_prev,
    output logic               grad_wr,
    output ig_pkg::img_addr_t  grad_addr,
    output ig_pkg::grad_word_u grad_do,
    output logic               done
);
    import ig_pkg::*;

    logic [8:0]               lead_cnt;
    logic                     in_window;
    img_addr_t                pos;        // Output position j.
    logic [$clog2(img_w)-1:0] col;
    logic [$clog2(img_h)-1:0] row;
    pixel_t                   prev_pix;   // Pixel below position j.
    grad_t                    gx_diff;
    grad_t                    gy_diff;
    grad_word_u               next_word;
    logic                     step;

    // The first output needs the pixel below it, which is one row plus one
    // beat into the stream.
    assign in_window = (lead_cnt == 9'(img_w + 1));
    assign step      = beat.valid && in_window && !done;

    always_ff @(posedge clk) begin
        if (reset) begin
            lead_cnt <= '0;
        end else if (beat.valid && !in_window) begin
            lead_cnt <= lead_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            prev_pix <= beat.pixel;
        end
    end

    // Position, column and row advance together on each productive beat.
    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
            col <= '0;
            row <= '0;
        end else if (step) begin
            pos <= pos + 1'b1;
            if (col == img_w - 1) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Zero-extended operands, so the 10-bit result is the signed difference.
    assign gx_diff = {2'b00, row_tap} - {2'b00, row_tap_prev};
    assign gy_diff = {2'b00, prev_pix} - {2'b00, row_tap_prev};

    always_comb begin
        next_word.fields.gx = (col == img_w - 1) ? '0 : gx_diff;  // No right neighbour.
        next_word.fields.gy = (row == img_h - 1) ? '0 : gy_diff;  // No neighbour below.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= step;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            grad_addr <= pos;
            grad_do   <= next_word;
        end
    end

    // Done follows the write of the last position and holds until reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (grad_wr && grad_addr == img_addr_t'(pix_count - 1)) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/image_gradient.sv */
`timescale 1ns/1ps
`default_nettype none

module image_gradient (
    input  logic               clk,
    input  logic               reset,
    output logic               img_rd,
    output ig_pkg::img_addr_t  img_addr,
    input  ig_pkg::pixel_t     img_di,
    output logic               grad_wr,
    output ig_pkg::img_addr_t  grad_addr,
    output ig_pkg::grad_word_u grad_do,
    output logic               done
);
    import ig_pkg::*;

    pix_beat_s beat;          // Pixel stream from the reader.
    pixel_t    row_tap;       // Pixel one row back.
    pixel_t    row_tap_prev;  // Same tap, one beat earlier.

    image_reader u_reader (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .beat     (beat)
    );

    line_buffer u_line_buf (
        .clk          (clk),
        .reset        (reset),
        .beat         (beat),
        .row_tap      (row_tap),
        .row_tap_prev (row_tap_prev)
    );

    gradient_unit u_grad (
        .clk          (clk),
        .reset        (reset),
        .beat         (beat),
        .row_tap      (row_tap),
        .row_tap_prev (row_tap_prev),
        .grad_wr      (grad_wr),
        .grad_addr    (grad_addr),
        .grad_do      (grad_do),
        .done         (done)
    );

endmodule

`default_nettype wire

/* sim/image_gradient_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module image_gradient_properties (
    input logic              clk,
    input logic              reset,
    input logic              img_rd,
    input ig_pkg::img_addr_t img_addr,
    input logic              grad_wr,
    input ig_pkg::img_addr_t grad_addr,
    input logic              done
);
    import ig_pkg::*;

    localparam img_addr_t last_addr = img_addr_t'(pix_count - 1);

    int        err_cnt;       // Failed assertions, read by the testbench.
    logic      rd_finished;   // The last image address has been requested.
    logic      wr_started;    // At least one gradient word has been written.
    img_addr_t last_wr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_finished  <= 1'b0;
            wr_started   <= 1'b0;
            last_wr_addr <= '0;
        end else begin
            if (img_rd && img_addr == last_addr) begin
                rd_finished <= 1'b1;
            end
            if (grad_wr) begin
                wr_started   <= 1'b1;
                last_wr_addr <= grad_addr;
            end
        end
    end

    // Outputs are idle one cycle after reset.
    reset_idle: assert property (@(posedge clk) reset |=> !img_rd && !grad_wr && !done)
        else begin
            err_cnt++;
            $error("Outputs not idle after reset");
        end

    read_start: assert property (@(posedge clk) disable iff (reset)
        $rose(img_rd) |-> img_addr == '0)
        else begin
            err_cnt++;
            $error("Image reads do not start at address 0");
        end

    read_step: assert property (@(posedge clk) disable iff (reset)
        img_rd && img_addr != last_addr |=> img_rd && img_addr == $past(img_addr) + 1'b1)
        else begin
            err_cnt++;
            $error("Image read address did not step by one");
        end

    // Once the last address went out, the read strobe stays low.
    read_end: assert property (@(posedge clk) disable iff (reset)
        (img_rd && img_addr == last_addr) || rd_finished |=> !img_rd)
        else begin
            err_cnt++;
            $error("Image read after the last address");
        end

    write_first: assert property (@(posedge clk) disable iff (reset)
        grad_wr && !wr_started |-> grad_addr == '0)
        else begin
            err_cnt++;
            $error("First gradient write not at address 0");
        end

    write_step: assert property (@(posedge clk) disable iff (reset)
        grad_wr && wr_started |-> grad_addr == last_wr_addr + 1'b1)
        else begin
            err_cnt++;
            $error("Gradient write address did not step by one");
        end

    done_after_last: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> $past(grad_wr && grad_addr == last_addr))
        else begin
            err_cnt++;
            $error("Done rose without the last write");
        end

    done_quiet: assert property (@(posedge clk) disable iff (reset) done |-> !grad_wr)
        else begin
            err_cnt++;
            $error("Gradient write while done is high");
        end

    done_holds: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else begin
            err_cnt++;
            $error("Done fell before reset");
        end

endmodule

`default_nettype wire

/* sim/tb_image_gradient.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_image_gradient;
    import ig_pkg::*;

    localparam int done_limit   = pix_count + 1000;  // Well past the fixed latency.
    localparam int drain_cycles = 32;

    logic       clk;
    logic       reset;
    logic       img_rd;
    img_addr_t  img_addr;
    pixel_t     img_di;
    logic       grad_wr;
    img_addr_t  grad_addr;
    grad_word_u grad_do;
    logic       done;

    pixel_t      image [pix_count];
    logic [31:0] lfsr_state;

    int value_errs;
    int reads_seen;
    int writes_seen;
    int wait_cycles;
    int total_errs;

    image_gradient UUT (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    bind image_gradient image_gradient_properties u_props (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic fill_image();
        pixel_t p;
        lfsr_state = 32'hdc78_1724;
        for (int i = 0; i < pix_count; i++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_next(lfsr_state);  // One step per pixel bit.
                p[b]       = lfsr_state[0];
            end
            image[i] = p;
        end
    endtask

    // Right neighbour minus the pixel, zero in the last column.
    function automatic grad_t expected_gx(input int j);
        if (j % img_w == img_w - 1) begin
            return '0;
        end
        return grad_t'(int'(image[j + 1]) - int'(image[j]));
    endfunction

    // Pixel below minus the pixel, zero in the last row.
    function automatic grad_t expected_gy(input int j);
        if (j / img_w == img_h - 1) begin
            return '0;
        end
        return grad_t'(int'(image[j + img_w]) - int'(image[j]));
    endfunction

    task automatic check_write(input img_addr_t addr, input grad_word_u word);
        grad_t exp_gx;
        grad_t exp_gy;
        exp_gx = expected_gx(int'(addr));
        exp_gy = expected_gy(int'(addr));
        assert (addr == img_addr_t'(writes_seen)) else begin
            value_errs++;
            $display("Fail at %0t: write address %0d, expected %0d", $time, addr, writes_seen);
        end
        assert (word.fields.gx == exp_gx) else begin
            value_errs++;
            $display("Fail at %0t: gx at %0d is %0d, expected %0d",
                     $time, addr, word.fields.gx, exp_gx);
        end
        assert (word.fields.gy == exp_gy) else begin
            value_errs++;
            $display("Fail at %0t: gy at %0d is %0d, expected %0d",
                     $time, addr, word.fields.gy, exp_gy);
        end
        writes_seen++;
    endtask

    // Image memory with a one-cycle read.
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= image[img_addr];
        end
    end

    // Outputs are checked mid-cycle, where they are stable.
    always @(negedge clk) begin
        if (!reset && img_rd) begin
            assert (img_addr == img_addr_t'(reads_seen)) else begin
                value_errs++;
                $display("Fail at %0t: read address %0d, expected %0d",
                         $time, img_addr, reads_seen);
            end
            reads_seen++;
        end
        if (!reset && grad_wr) begin
            check_write(grad_addr, grad_do);
        end
    end

    initial begin
        reset       = 1'b1;
        img_di      = '0;
        value_errs  = 0;
        reads_seen  = 0;
        writes_seen = 0;
        fill_image();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        wait_cycles = 0;
        while (!done && wait_cycles < done_limit) begin
            @(negedge clk);
            wait_cycles++;
        end

        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles after reset", done_limit);
            $display("TEST FAILED");
        end else begin
            repeat (drain_cycles) @(negedge clk);  // Done must hold with no more writes.
            assert (reads_seen == pix_count) else begin
                value_errs++;
                $display("Fail at %0t: %0d image reads, expected %0d",
                         $time, reads_seen, pix_count);
            end
            assert (writes_seen == pix_count) else begin
                value_errs++;
                $display("Fail at %0t: %0d writes, expected %0d", $time, writes_seen, pix_count);
            end
            total_errs = value_errs + UUT.u_props.err_cnt;
            $display("Errors: %0d value, %0d protocol, %0d total",
                     value_errs, UUT.u_props.err_cnt, total_errs);
            if (total_errs == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/ig_pkg.sv
source/image_reader.sv
source/line_buffer.sv
source/gradient_unit.sv
source/image_gradient.sv
sim/image_gradient_properties.sv
sim/tb_image_gradient.sv
